/* Makefile */
TOP := scalar_fixed_unit_tb
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
design/scalar_fixed_pkg.sv
design/scalar_fixed_multiplier.sv
design/scalar_fixed_executor.sv
design/scalar_request_arbiter.sv
design/scalar_fixed_unit.sv
verif/scalar_fixed_unit_tb.sv

/* design/scalar_fixed_executor.sv */
// Executes one scalar request at a time.
// Add and subtract finish in one cycle; multiply goes through the shift-add multiplier.
`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_executor
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  scalar_req_t req,
  output logic        ready,
  output scalar_rsp_t rsp
);

  // Operation in flight
  logic busy;

  // Multiply path
  logic        mul_start;
  fixed_t      mul_a;
  fixed_t      mul_b;
  logic        mul_ready;
  scalar_rsp_t mul_rsp;

  // Add/sub path
  logic                      alu_ready;
  scalar_rsp_t               alu_rsp;
  logic signed [WORD_SIZE:0] sum_wide;
  logic                      sum_ovf;
  scalar_rsp_t               sum_rsp;

  ////////////////////
  // Add / subtract
  ////////////////////

  // One guard bit catches the carry out of the sign
  always_comb begin
    if (req.op == OP_SUB) begin
      sum_wide = {req.operand_a[WORD_SIZE-1], req.operand_a} -
                 {req.operand_b[WORD_SIZE-1], req.operand_b};
    end else begin
      sum_wide = {req.operand_a[WORD_SIZE-1], req.operand_a} +
                 {req.operand_b[WORD_SIZE-1], req.operand_b};
    end
  end

  // Guard and sign disagree on overflow
  assign sum_ovf          = sum_wide[WORD_SIZE] != sum_wide[WORD_SIZE-1];
  assign sum_rsp.result   = sum_ovf ? (sum_wide[WORD_SIZE] ? FIXED_MIN : FIXED_MAX) :
                            sum_wide[WORD_SIZE-1:0];
  assign sum_rsp.overflow = sum_ovf;

  // Control and handshake pulses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      mul_start <= 1'b0;
      alu_ready <= 1'b0;
    end else begin
      alu_ready <= start && (req.op != OP_MUL);
      mul_start <= start && (req.op == OP_MUL);
      if (start) begin
        busy <= 1'b1;
      end else if (ready) begin
        busy <= 1'b0;
      end
    end
  end

  // Operands for the multiplier, add/sub result
  always_ff @(posedge CLK) begin
    if (start) begin
      mul_a   <= req.operand_a;
      mul_b   <= req.operand_b;
      alu_rsp <= sum_rsp;
    end
  end

  scalar_fixed_multiplier #(
    .FRAC_SIZE (FRAC_SIZE)
  ) u_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .start     (mul_start),
    .operand_a (mul_a),
    .operand_b (mul_b),
    .ready     (mul_ready),
    .rsp       (mul_rsp)
  );

  // The two paths never finish in the same cycle
  assign ready = alu_ready | mul_ready;
  assign rsp   = mul_ready ? mul_rsp : alu_rsp;

  a_no_start_busy : assert property (@(posedge CLK) disable iff (RST) busy |-> !start)
    else $error("executor started during an operation");

endmodule

`default_nettype wire

/* design/scalar_fixed_multiplier.sv */
// Iterative signed fixed-point multiplier with a START/READY handshake.
// One shift-add step per bit, then a scale and saturate step; READY is a single pulse.
`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_multiplier
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  fixed_t      operand_a,
  input  fixed_t      operand_b,
  output logic        ready,
  output scalar_rsp_t rsp
);

  localparam int PROD_SIZE = 2 * WORD_SIZE;
  localparam int CNT_SIZE  = $clog2(WORD_SIZE + 1);
  // Count value once all partial products are summed
  localparam logic [CNT_SIZE-1:0] LAST_STEP = CNT_SIZE'(WORD_SIZE);

  // Control
  logic                 busy;
  logic [CNT_SIZE-1:0]  step_cnt;

  // Datapath registers
  logic                 neg_q;
  logic [PROD_SIZE-1:0] acc_q;
  logic [PROD_SIZE-1:0] mcand_q;
  logic [WORD_SIZE-1:0] mplier_q;

  // Combinational helpers
  logic [WORD_SIZE-1:0]        mag_a;
  logic [WORD_SIZE-1:0]        mag_b;
  logic signed [PROD_SIZE-1:0] prod_signed;
  logic signed [PROD_SIZE-1:0] prod_scaled;
  logic                        fits;
  scalar_rsp_t                 rsp_next;

  ////////////////////
  // Magnitudes
  ////////////////////

  // Most negative input maps to 2^(W-1), still fits unsigned
  assign mag_a = operand_a[WORD_SIZE-1] ? -operand_a : operand_a;
  assign mag_b = operand_b[WORD_SIZE-1] ? -operand_b : operand_b;

  ////////////////////
  // Scale and saturate
  ////////////////////

  // Magnitude product stays below 2^63, no sign bit clash
  assign prod_signed = neg_q ? -$signed(acc_q) : $signed(acc_q);
  // Arithmetic shift floors toward minus infinity
  assign prod_scaled = prod_signed >>> FRAC_SIZE;
  // In range when every bit above the result MSB copies it
  assign fits = (prod_scaled[PROD_SIZE-1:WORD_SIZE-1] == '0) ||
                (prod_scaled[PROD_SIZE-1:WORD_SIZE-1] == '1);

  assign rsp_next.result   = fits ? prod_scaled[WORD_SIZE-1:0] :
                             (prod_scaled[PROD_SIZE-1] ? FIXED_MIN : FIXED_MAX);
  assign rsp_next.overflow = !fits;

  // Step counter and READY pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        // First partial product is folded into the load
        busy     <= 1'b1;
        step_cnt <= CNT_SIZE'(1);
      end else if (busy) begin
        if (step_cnt == LAST_STEP) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  // Shift-add datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      neg_q    <= operand_a[WORD_SIZE-1] ^ operand_b[WORD_SIZE-1];
      acc_q    <= mag_b[0] ? PROD_SIZE'(mag_a) : '0;
      mcand_q  <= PROD_SIZE'(mag_a) << 1;
      mplier_q <= mag_b >> 1;
    end else if (busy) begin
      if (step_cnt == LAST_STEP) begin
        rsp <= rsp_next;
      end else begin
        // Add shifted multiplicand when the current bit is set
        if (mplier_q[0]) begin
          acc_q <= acc_q + mcand_q;
        end
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
      end
    end
  end

  // No new operand pair while a product is still being formed
  a_no_start_busy : assert property (@(posedge CLK) disable iff (RST) busy |-> !start)
    else $error("multiplier started while busy");

endmodule

`default_nettype wire

/* design/scalar_fixed_pkg.sv */
// Shared types for the fixed-point scalar unit.
// Modules pull these in with a wildcard import in their header.
`default_nettype none

package scalar_fixed_pkg;

  ////////////////////
  // Word format
  ////////////////////

  // Width of every operand and result
  localparam int WORD_SIZE = 32;

  // Two's complement fixed-point word, binary point set by FRAC_SIZE
  typedef logic signed [WORD_SIZE-1:0] fixed_t;

  // Saturation limits shared by add/sub and multiply
  localparam fixed_t FIXED_MAX = fixed_t'({1'b0, {(WORD_SIZE-1){1'b1}}});
  localparam fixed_t FIXED_MIN = fixed_t'({1'b1, {(WORD_SIZE-1){1'b0}}});

  ////////////////////
  // Operations
  ////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } scalar_op_e;

  // One client request, 66 bits
  typedef struct packed {
    scalar_op_e op;
    fixed_t     operand_a;
    fixed_t     operand_b;
  } scalar_req_t;

  // Result plus saturation flag, 33 bits
  typedef struct packed {
    fixed_t result;
    logic   overflow;
  } scalar_rsp_t;

endpackage

`default_nettype wire

/* design/scalar_fixed_unit.sv */
// Top of the shared fixed-point unit.
// Clients attach to the req/ack ports; one executor is shared round-robin.
`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_unit
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16,
  parameter int CLIENTS   = 2
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic [CLIENTS-1:0] req,
  input  scalar_req_t        req_data [CLIENTS],
  output logic [CLIENTS-1:0] ack,
  output scalar_rsp_t        rsp_data [CLIENTS]
);

  // Arbiter to executor link
  logic        exec_start;
  scalar_req_t exec_req;
  logic        exec_ready;
  scalar_rsp_t exec_rsp;

  scalar_request_arbiter #(
    .CLIENTS (CLIENTS)
  ) u_arbiter (
    .CLK        (CLK),
    .RST        (RST),
    .req        (req),
    .req_data   (req_data),
    .ack        (ack),
    .rsp_data   (rsp_data),
    .exec_start (exec_start),
    .exec_req   (exec_req),
    .exec_ready (exec_ready),
    .exec_rsp   (exec_rsp)
  );

  scalar_fixed_executor #(
    .FRAC_SIZE (FRAC_SIZE)
  ) u_executor (
    .CLK   (CLK),
    .RST   (RST),
    .start (exec_start),
    .req   (exec_req),
    .ready (exec_ready),
    .rsp   (exec_rsp)
  );

endmodule

`default_nettype wire

/* design/scalar_request_arbiter.sv */
// Round-robin arbiter between the client four-phase ports and the executor.
// Issues one request at a time and keeps each client's response until its req drops.
`timescale 1ns/1ps
`default_nettype none

module scalar_request_arbiter
  import scalar_fixed_pkg::*;
#(
  parameter int CLIENTS = 2
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic [CLIENTS-1:0] req,
  input  scalar_req_t        req_data [CLIENTS],
  output logic [CLIENTS-1:0] ack,
  output scalar_rsp_t        rsp_data [CLIENTS],
  output logic               exec_start,
  output scalar_req_t        exec_req,
  input  logic               exec_ready,
  input  scalar_rsp_t        exec_rsp
);

  localparam int IDX_SIZE = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;
  localparam logic [IDX_SIZE-1:0] LAST_IDX = IDX_SIZE'(CLIENTS - 1);

  logic [CLIENTS-1:0]  req_q;
  logic [CLIENTS-1:0]  eligible;
  logic                running;
  logic [IDX_SIZE-1:0] owner;
  // Highest priority client for the next grant
  logic [IDX_SIZE-1:0] rr_ptr;
  logic [IDX_SIZE-1:0] grant_idx;
  logic                grant_found;
  logic                issue;

  ////////////////////
  // Grant selection
  ////////////////////

  // A running operation blocks every grant, its owner included
  assign eligible = req_q & ~ack;
  assign issue    = !running && grant_found;

  // Scan from rr_ptr upward with wrap
  always_comb begin : rr_search
    int idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < CLIENTS; k++) begin
      idx = int'(rr_ptr) + k;
      if (idx >= CLIENTS) begin
        idx = idx - CLIENTS;
      end
      if (!grant_found && eligible[idx]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_SIZE'(idx);
      end
    end
  end

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      req_q      <= '0;
      ack        <= '0;
      running    <= 1'b0;
      owner      <= '0;
      rr_ptr     <= '0;
      exec_start <= 1'b0;
    end else begin
      req_q      <= req;
      exec_start <= issue;
      if (issue) begin
        running <= 1'b1;
        owner   <= grant_idx;
        rr_ptr  <= (grant_idx == LAST_IDX) ? '0 : grant_idx + 1'b1;
      end else if (exec_ready) begin
        running <= 1'b0;
      end
      // Ack up on the owner's result, down once that client lets go
      for (int i = 0; i < CLIENTS; i++) begin
        if (exec_ready && owner == IDX_SIZE'(i)) begin
          ack[i] <= 1'b1;
        end else if (ack[i] && !req_q[i]) begin
          ack[i] <= 1'b0;
        end
      end
    end
  end

  // Issued request and per-client result holding
  always_ff @(posedge CLK) begin
    if (issue) begin
      exec_req <= req_data[grant_idx];
    end
    for (int i = 0; i < CLIENTS; i++) begin
      if (exec_ready && owner == IDX_SIZE'(i)) begin
        rsp_data[i] <= exec_rsp;
      end
    end
  end

  // Req as seen at the edge that raised ack
  for (genvar g = 0; g < CLIENTS; g++) begin : g_ack_check
    a_ack_on_req : assert property (@(posedge CLK) disable iff (RST)
                                    $rose(ack[g]) |-> $past(req[g]))
      else $error("ack raised without a pending req");
  end

  // Executor result only for an issued operation
  a_ready_in_op : assert property (@(posedge CLK) disable iff (RST) exec_ready |-> running)
    else $error("executor ready with no operation running");

endmodule

`default_nettype wire

/* verif/scalar_fixed_unit_tb.sv */
// Directed testbench for the shared fixed-point unit with two clients.
// Each test drives full four-phase transactions and checks against a reference model.
`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_unit_tb
  import scalar_fixed_pkg::*;
;

  // Must match the DUT defaults
  localparam int FRAC_BITS = 16;
  localparam int NUM_CLIENTS = 2;
  localparam int ROUNDS = 4;
  localparam int RANDOM_TXNS = 40;
  // add/sub 6, mul 6, handshake 1, concurrent, random
  localparam int TXN_COUNT = 6 + 6 + 1 + NUM_CLIENTS * ROUNDS + RANDOM_TXNS;
  localparam int TIMEOUT_CYCLES = (TXN_COUNT + 4) * (WORD_SIZE + 10);
  localparam longint MAX_VAL = 64'sh0000_0000_7FFF_FFFF;
  localparam longint MIN_VAL = -64'sh0000_0000_8000_0000;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                   CLK;
  logic                   RST;
  logic [NUM_CLIENTS-1:0] req;
  scalar_req_t            req_data [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] ack;
  scalar_rsp_t            rsp_data [NUM_CLIENTS];

  int          cycle_cnt;
  logic [31:0] lfsr;
  int          done_order [$];
  scalar_req_t round_req [NUM_CLIENTS][ROUNDS];

  scalar_fixed_unit DUT (
    .CLK      (CLK),
    .RST      (RST),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp_data (rsp_data)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) cycle_cnt <= cycle_cnt + 1;

  // Hang guard sized from the transaction count
  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: DUT gave no ack within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on timeout");
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // One cycle, landing 1 ns after the edge
  task automatic wait_cycle();
    @(posedge CLK);
    #1;
  endtask

  // Galois LFSR, one step per output bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ LFSR_TAPS;
    return out;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // 20-bit signed value, keeps most products in range
  function automatic fixed_t small_operand();
    logic [31:0] v;
    v = lfsr_bits(20);
    return {{12{v[19]}}, v[19:0]};
  endfunction

  function automatic scalar_req_t make_req(input scalar_op_e op, input fixed_t a,
                                           input fixed_t b);
    scalar_req_t r;
    r.op = op;
    r.operand_a = a;
    r.operand_b = b;
    return r;
  endfunction

  // Exact arithmetic in 64 bits, then clamp to the word range
  function automatic scalar_rsp_t model_rsp(input scalar_req_t rq);
    longint      a;
    longint      b;
    longint      full;
    scalar_rsp_t r;
    a = longint'(rq.operand_a);
    b = longint'(rq.operand_b);
    case (rq.op)
      OP_ADD:  full = a + b;
      OP_SUB:  full = a - b;
      default: full = (a * b) >>> FRAC_BITS;
    endcase
    r.overflow = (full > MAX_VAL) || (full < MIN_VAL);
    if (full > MAX_VAL) r.result = MAX_VAL[WORD_SIZE-1:0];
    else if (full < MIN_VAL) r.result = MIN_VAL[WORD_SIZE-1:0];
    else r.result = full[WORD_SIZE-1:0];
    return r;
  endfunction

  task automatic compare_rsp(input string name, input scalar_rsp_t got,
                             input scalar_rsp_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: result %h overflow %h, expected result %h overflow %h",
               name, got.result, got.overflow, exp.result, exp.overflow);
      stop_on_error();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Full four-phase transaction; hold keeps req up after ack
  task automatic do_transaction(input int client, input scalar_req_t rq, input int hold);
    scalar_rsp_t exp;
    scalar_rsp_t held;
    exp = model_rsp(rq);
    req_data[client] = rq;
    req[client] = 1'b1;
    while (ack[client] !== 1'b1) wait_cycle();
    done_order.push_back(client);
    compare_rsp($sformatf("rsp_data[%0d]", client), rsp_data[client], exp);
    held = rsp_data[client];
    repeat (hold) begin
      wait_cycle();
      compare_bit($sformatf("ack[%0d] held", client), ack[client], 1'b1);
      compare_rsp($sformatf("rsp_data[%0d] held", client), rsp_data[client], held);
    end
    req[client] = 1'b0;
    while (ack[client] !== 1'b0) wait_cycle();
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_idle();
    repeat (10) begin
      wait_cycle();
      compare_bit("ack[0] idle", ack[0], 1'b0);
      compare_bit("ack[1] idle", ack[1], 1'b0);
    end
  endtask

  task automatic test_add_sub();
    // 1.5 + -2.25, then -1 - 3.25
    do_transaction(0, make_req(OP_ADD, 32'h0001_8000, 32'hFFFD_C000), 0);
    do_transaction(0, make_req(OP_SUB, 32'hFFFF_0000, 32'h0003_4000), 0);
    do_transaction(0, make_req(OP_SUB, 32'h1234_5678, 32'h1234_5679), 0);
    // Saturating cases
    do_transaction(0, make_req(OP_ADD, 32'h7FFF_0000, 32'h0002_0000), 0);
    do_transaction(0, make_req(OP_SUB, 32'h8000_1000, 32'h0001_0000), 0);
    do_transaction(0, make_req(OP_ADD, 32'h8000_0000, 32'hFFFF_FFFF), 0);
  endtask

  task automatic test_multiply();
    // 1.5 * -2.25 and -0.5 * 0.75
    do_transaction(1, make_req(OP_MUL, 32'h0001_8000, 32'hFFFD_C000), 0);
    do_transaction(1, make_req(OP_MUL, 32'hFFFF_8000, 32'h0000_C000), 0);
    // Tiny negative product floors to -1 LSB
    do_transaction(1, make_req(OP_MUL, 32'hFFFF_FFFF, 32'h0000_0001), 0);
    do_transaction(1, make_req(OP_MUL, 32'h0100_0000, 32'h0100_0000), 0);
    do_transaction(1, make_req(OP_MUL, 32'h0100_0000, 32'hFF00_0000), 0);
    do_transaction(1, make_req(OP_MUL, 32'h8000_0000, 32'h8000_0000), 0);
  endtask

  task automatic test_handshake();
    do_transaction(0, make_req(OP_MUL, 32'h0003_0000, 32'hFFFE_8000), 6);
  endtask

  task automatic client_rounds(input int client);
    for (int r = 0; r < ROUNDS; r++) do_transaction(client, round_req[client][r], 0);
  endtask

  task automatic test_concurrent();
    // Operands fixed before the fork so both clients see a set order
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      for (int r = 0; r < ROUNDS; r++) begin
        round_req[c][r] = make_req(OP_MUL, small_operand(), small_operand());
      end
    end
    done_order.delete();
    fork
      client_rounds(0);
      client_rounds(1);
    join
    for (int k = 1; k < done_order.size(); k++) begin
      if (done_order[k] == done_order[k-1]) begin
        $display("Completions did not alternate: client %0d finished twice in a row",
                 done_order[k]);
        stop_on_error();
      end
    end
  endtask

  task automatic test_random();
    int          client;
    logic [31:0] op_sel;
    scalar_op_e  op;
    fixed_t      a;
    fixed_t      b;
    for (int n = 0; n < RANDOM_TXNS; n++) begin
      client = int'(lfsr_bits(1));
      op_sel = lfsr_bits(2);
      op = (op_sel == 0) ? OP_ADD : (op_sel == 1) ? OP_SUB : OP_MUL;
      if (op == OP_MUL) begin
        a = small_operand();
        b = small_operand();
      end else begin
        a = lfsr_bits(32);
        b = lfsr_bits(32);
      end
      do_transaction(client, make_req(op, a, b), 0);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    lfsr = 32'd12;
    RST = 1'b1;
    req = '0;
    for (int c = 0; c < NUM_CLIENTS; c++) req_data[c] = '0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;
    test_reset_idle();
    test_add_sub();
    test_multiply();
    test_handshake();
    test_concurrent();
    test_random();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
